//--- Bender.yml
package:
  name: cache_controller

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_pkg.sv
      - hw/req_dispatch.sv
      - hw/cache_bank.sv
      - hw/resp_merge.sv
      - hw/cache_controller.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/mem_model.sv
      - verif/tb_cache_controller.sv

//--- hw/cache_bank.sv
// Cache bank: tag, valid and line arrays with lookup, refill and write-through
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module cache_bank import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic bank_val,
	input logic bank_we,
	input addr_u bank_addr,
	input word_t bank_wdata,
	input logic refill_val,
	input line_t refill_line,
	input logic mem_taken,
	input logic done,
	output logic bmem_val,
	output logic bmem_we,
	output addr_u bmem_addr,
	output word_t bmem_wdata,
	output logic bresp_val,
	output word_t bresp_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MEM_REQ,
		S_MEM_WAIT,
		S_RESP
	} state_e;

	state_e state;
	logic [TAG_W-1:0] tag_arr [`CC_LINES_PER_BANK];
	line_t data_arr [`CC_LINES_PER_BANK];
	logic [`CC_LINES_PER_BANK-1:0] valid_arr;
	line_t line_rd;
	word_t hit_word;
	logic hit;

	// Lookup
	assign line_rd = data_arr[bank_addr.f.index];
	assign hit_word = line_rd[bank_addr.f.word*`CC_WORD_W +: `CC_WORD_W];
	assign hit = valid_arr[bank_addr.f.index] && (tag_arr[bank_addr.f.index] == bank_addr.f.tag);

	// ---------------------------------------------------------------------
	// Bank FSM
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			valid_arr <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (bank_val) begin
						// Writes always go to memory
						state <= (!bank_we && hit) ? S_RESP : S_MEM_REQ;
					end
				end
				S_MEM_REQ: begin
					if (mem_taken) begin
						state <= S_MEM_WAIT;
					end
				end
				S_MEM_WAIT: begin
					if (refill_val) begin
						state <= S_RESP;
						if (!bank_we) begin
							valid_arr[bank_addr.f.index] <= 1'b1;
						end
					end
				end
				default: begin
					if (done) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Arrays and response word
	always_ff @(posedge clk) begin
		if (state == S_IDLE && bank_val) begin
			bresp_data <= bank_we ? '0 : hit_word;
			if (bank_we && hit) begin
				data_arr[bank_addr.f.index][bank_addr.f.word*`CC_WORD_W +: `CC_WORD_W] <= bank_wdata;
			end
		end
		if (state == S_MEM_WAIT && refill_val && !bank_we) begin
			data_arr[bank_addr.f.index] <= refill_line;
			tag_arr[bank_addr.f.index] <= bank_addr.f.tag;
			bresp_data <= refill_line[bank_addr.f.word*`CC_WORD_W +: `CC_WORD_W];
		end
	end

	// ---------------------------------------------------------------------
	// Memory request, line aligned for reads
	// ---------------------------------------------------------------------
	always_comb begin
		bmem_addr = bank_addr;
		if (!bank_we) begin
			bmem_addr.f.word = '0;
			bmem_addr.f.byte_off = '0;
		end
	end

	assign bmem_val = (state == S_MEM_REQ);
	assign bmem_we = bank_we;
	assign bmem_wdata = bank_wdata;
	assign bresp_val = (state == S_RESP);

	a_refill_expected: assert property (@(posedge clk) disable iff (reset)
		refill_val |-> state == S_MEM_WAIT);

endmodule

`default_nettype wire

//--- hw/cache_config.svh
// Cache controller widths, geometry, special addresses and reset boundary
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ---------------------------------------------------------------------
// Data path widths
// ---------------------------------------------------------------------
`define CC_ADDR_W 32
`define CC_WORD_W 32

// Cache geometry
`define CC_LINE_WORDS 4
`define CC_NUM_BANKS 2
`define CC_LINES_PER_BANK 8

// ---------------------------------------------------------------------
// Address map and security
// ---------------------------------------------------------------------
`define CC_DIRECT_ADDR 32'h0000_0000
`define CC_CTRL_ADDR 32'h0000_0004
`define CC_BOUNDARY_RESET 32'h0000_c000
`define CC_DOMAIN_HIGH 1'b1

`endif

//--- hw/cache_controller.sv
// Cache controller top: dispatcher, cache banks and response merger
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module cache_controller import cache_pkg::*; (
	input logic clk,
	input logic reset,

	input logic procreq_val,
	input logic procreq_we,
	input logic procreq_domain,
	input addr_u procreq_addr,
	input word_t procreq_wdata,
	output logic procreq_rdy,

	output logic procresp_val,
	output word_t procresp_data,
	input logic procresp_rdy,

	output logic memreq_val,
	output logic memreq_we,
	output addr_u memreq_addr,
	output word_t memreq_wdata,
	input logic memreq_rdy,

	input logic memresp_val,
	input line_t memresp_line
);

	logic [`CC_NUM_BANKS-1:0] bank_val;
	logic bank_we;
	addr_u bank_addr;
	word_t bank_wdata;
	logic direct_val;
	logic ctrl_val;
	logic done;

	logic [`CC_NUM_BANKS-1:0] bmem_val;
	logic [`CC_NUM_BANKS-1:0] bmem_we;
	addr_u bmem_addr [`CC_NUM_BANKS];
	word_t bmem_wdata [`CC_NUM_BANKS];
	logic [`CC_NUM_BANKS-1:0] bresp_val;
	word_t bresp_data [`CC_NUM_BANKS];

	logic [`CC_NUM_BANKS-1:0] refill_val;
	logic [`CC_NUM_BANKS-1:0] mem_taken;
	line_t refill_line;

	req_dispatch i_dispatch (
		.clk(clk),
		.reset(reset),
		.procreq_val(procreq_val),
		.procreq_we(procreq_we),
		.procreq_domain(procreq_domain),
		.procreq_addr(procreq_addr),
		.procreq_wdata(procreq_wdata),
		.done(done),
		.procreq_rdy(procreq_rdy),
		.bank_val(bank_val),
		.bank_we(bank_we),
		.bank_addr(bank_addr),
		.bank_wdata(bank_wdata),
		.direct_val(direct_val),
		.ctrl_val(ctrl_val)
	);

	for (genvar g = 0; g < `CC_NUM_BANKS; g++) begin : g_bank
		cache_bank i_bank (
			.clk(clk),
			.reset(reset),
			.bank_val(bank_val[g]),
			.bank_we(bank_we),
			.bank_addr(bank_addr),
			.bank_wdata(bank_wdata),
			.refill_val(refill_val[g]),
			.refill_line(refill_line),
			.mem_taken(mem_taken[g]),
			.done(done),
			.bmem_val(bmem_val[g]),
			.bmem_we(bmem_we[g]),
			.bmem_addr(bmem_addr[g]),
			.bmem_wdata(bmem_wdata[g]),
			.bresp_val(bresp_val[g]),
			.bresp_data(bresp_data[g])
		);
	end

	resp_merge i_merge (
		.clk(clk),
		.reset(reset),
		.bmem_val(bmem_val),
		.bmem_we(bmem_we),
		.bmem_addr(bmem_addr),
		.bmem_wdata(bmem_wdata),
		.bresp_val(bresp_val),
		.bresp_data(bresp_data),
		.direct_val(direct_val),
		.bank_we(bank_we),
		.bank_addr(bank_addr),
		.bank_wdata(bank_wdata),
		.ctrl_val(ctrl_val),
		.memreq_val(memreq_val),
		.memreq_we(memreq_we),
		.memreq_addr(memreq_addr),
		.memreq_wdata(memreq_wdata),
		.memreq_rdy(memreq_rdy),
		.memresp_val(memresp_val),
		.memresp_line(memresp_line),
		.mem_taken(mem_taken),
		.refill_val(refill_val),
		.refill_line(refill_line),
		.procresp_val(procresp_val),
		.procresp_data(procresp_data),
		.procresp_rdy(procresp_rdy),
		.done(done)
	);

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
// Shared cache types: word, line, address union and request route
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

	// Address field widths
	localparam int BYTE_OFF_W = $clog2(`CC_WORD_W / 8);
	localparam int WORD_OFF_W = $clog2(`CC_LINE_WORDS);
	localparam int BANK_W = $clog2(`CC_NUM_BANKS);
	localparam int INDEX_W = $clog2(`CC_LINES_PER_BANK);
	localparam int TAG_W = `CC_ADDR_W - INDEX_W - BANK_W - WORD_OFF_W - BYTE_OFF_W;

	typedef logic [`CC_WORD_W-1:0] word_t;
	typedef logic [`CC_LINE_WORDS*`CC_WORD_W-1:0] line_t;

	// ---------------------------------------------------------------------
	// Address, as a flat word or as cache fields
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [BANK_W-1:0] bank;
		logic [WORD_OFF_W-1:0] word;
		logic [BYTE_OFF_W-1:0] byte_off;
	} addr_fields_t;

	typedef union packed {
		logic [`CC_ADDR_W-1:0] flat;
		addr_fields_t f;
	} addr_u;

	// Uncached requests go out as direct
	typedef enum logic [1:0] {
		ROUTE_DIRECT = 2'd0,
		ROUTE_CTRL = 2'd1,
		ROUTE_EMPTY = 2'd2,
		ROUTE_CACHED = 2'd3
	} route_e;

endpackage

`default_nettype wire

//--- hw/req_dispatch.sv
// Request dispatcher with classification, issue strobes and the boundary register
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module req_dispatch import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic procreq_val,
	input logic procreq_we,
	input logic procreq_domain,
	input addr_u procreq_addr,
	input word_t procreq_wdata,
	input logic done,
	output logic procreq_rdy,
	output logic [`CC_NUM_BANKS-1:0] bank_val,
	output logic bank_we,
	output addr_u bank_addr,
	output word_t bank_wdata,
	output logic direct_val,
	output logic ctrl_val
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT
	} state_e;

	state_e state;
	route_e route;
	route_e route_next;
	logic accept;
	logic req_we;
	addr_u req_addr;
	word_t req_wdata;
	logic [`CC_ADDR_W-1:0] boundary;

	assign procreq_rdy = (state == S_IDLE);
	assign accept = procreq_val && procreq_rdy;

	// ---------------------------------------------------------------------
	// Classification
	// ---------------------------------------------------------------------
	always_comb begin
		if (procreq_addr.flat == `CC_DIRECT_ADDR) begin
			route_next = ROUTE_DIRECT;
		end else if (procreq_addr.flat == `CC_CTRL_ADDR) begin
			// Only the high domain may move the boundary
			if (procreq_domain == `CC_DOMAIN_HIGH) begin
				route_next = ROUTE_CTRL;
			end else begin
				route_next = ROUTE_EMPTY;
			end
		end else if (procreq_addr.flat < boundary) begin
			route_next = ROUTE_CACHED;
		end else begin
			route_next = ROUTE_DIRECT;
		end
	end

	// ---------------------------------------------------------------------
	// Control FSM and boundary register
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			boundary <= `CC_BOUNDARY_RESET;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					// Control responses can finish in the issue cycle
					state <= done ? S_IDLE : S_WAIT;
					if (route == ROUTE_CTRL) begin
						boundary <= req_wdata;
					end
				end
				default: begin
					if (done) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Request held stable until the next acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			req_we <= procreq_we;
			req_addr <= procreq_addr;
			req_wdata <= procreq_wdata;
			route <= route_next;
		end
	end

	// ---------------------------------------------------------------------
	// Issue strobes
	// ---------------------------------------------------------------------
	always_comb begin
		bank_val = '0;
		if (state == S_ISSUE && route == ROUTE_CACHED) begin
			bank_val[req_addr.f.bank] = 1'b1;
		end
	end

	assign direct_val = (state == S_ISSUE) && (route == ROUTE_DIRECT);
	assign ctrl_val = (state == S_ISSUE) && (route == ROUTE_CTRL || route == ROUTE_EMPTY);

	assign bank_we = req_we;
	assign bank_addr = req_addr;
	assign bank_wdata = req_wdata;

	// No stale response may complete while a bank or direct access is issued
	a_bank_onehot: assert property (@(posedge clk) disable iff (reset)
		(|bank_val || direct_val) |-> $onehot0(bank_val) && !done);

endmodule

`default_nettype wire

//--- hw/resp_merge.sv
// Response merger: memory port arbitration, refill routing and processor response
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module resp_merge import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [`CC_NUM_BANKS-1:0] bmem_val,
	input logic [`CC_NUM_BANKS-1:0] bmem_we,
	input addr_u bmem_addr [`CC_NUM_BANKS],
	input word_t bmem_wdata [`CC_NUM_BANKS],
	input logic [`CC_NUM_BANKS-1:0] bresp_val,
	input word_t bresp_data [`CC_NUM_BANKS],
	input logic direct_val,
	input logic bank_we,
	input addr_u bank_addr,
	input word_t bank_wdata,
	input logic ctrl_val,
	output logic memreq_val,
	output logic memreq_we,
	output addr_u memreq_addr,
	output word_t memreq_wdata,
	input logic memreq_rdy,
	input logic memresp_val,
	input line_t memresp_line,
	output logic [`CC_NUM_BANKS-1:0] mem_taken,
	output logic [`CC_NUM_BANKS-1:0] refill_val,
	output line_t refill_line,
	output logic procresp_val,
	output word_t procresp_data,
	input logic procresp_rdy,
	output logic done
);

	logic dir_req;
	logic dir_resp;
	word_t dir_data;
	logic ctrl_hold;
	logic outstanding;
	logic owner_direct;
	logic [BANK_W-1:0] owner_bank;
	logic [BANK_W-1:0] sel_bank;

	// ---------------------------------------------------------------------
	// Memory request mux, only one source active at a time
	// ---------------------------------------------------------------------
	always_comb begin
		memreq_val = dir_req;
		memreq_we = bank_we;
		memreq_addr = bank_addr;
		if (!bank_we) begin
			memreq_addr.f.word = '0;
			memreq_addr.f.byte_off = '0;
		end
		memreq_wdata = bank_wdata;
		sel_bank = '0;
		for (int i = 0; i < `CC_NUM_BANKS; i++) begin
			if (bmem_val[i]) begin
				memreq_val = 1'b1;
				memreq_we = bmem_we[i];
				memreq_addr = bmem_addr[i];
				memreq_wdata = bmem_wdata[i];
				sel_bank = BANK_W'(i);
			end
		end
	end

	assign mem_taken = bmem_val & {`CC_NUM_BANKS{memreq_rdy}};

	// Memory response goes to whoever issued the request
	always_comb begin
		for (int i = 0; i < `CC_NUM_BANKS; i++) begin
			refill_val[i] = memresp_val && outstanding && !owner_direct && (owner_bank == BANK_W'(i));
		end
	end

	assign refill_line = memresp_line;

	always_ff @(posedge clk) begin
		if (reset) begin
			dir_req <= 1'b0;
			dir_resp <= 1'b0;
			ctrl_hold <= 1'b0;
			outstanding <= 1'b0;
			owner_direct <= 1'b0;
			owner_bank <= '0;
		end else begin
			dir_req <= direct_val || (dir_req && !memreq_rdy);
			if (memreq_val && memreq_rdy) begin
				outstanding <= 1'b1;
				owner_direct <= !(|bmem_val);
				owner_bank <= sel_bank;
			end else if (memresp_val) begin
				outstanding <= 1'b0;
			end
			if (memresp_val && outstanding && owner_direct) begin
				dir_resp <= 1'b1;
			end else if (done) begin
				dir_resp <= 1'b0;
			end
			ctrl_hold <= (ctrl_val || ctrl_hold) && !done;
		end
	end

	// Word pick for direct reads
	always_ff @(posedge clk) begin
		if (memresp_val && owner_direct) begin
			dir_data <= bank_we ? '0 : memresp_line[bank_addr.f.word*`CC_WORD_W +: `CC_WORD_W];
		end
	end

	// ---------------------------------------------------------------------
	// Processor response
	// ---------------------------------------------------------------------
	always_comb begin
		procresp_data = dir_resp ? dir_data : '0;
		for (int i = 0; i < `CC_NUM_BANKS; i++) begin
			if (bresp_val[i]) begin
				procresp_data = bresp_data[i];
			end
		end
	end

	assign procresp_val = ctrl_val || ctrl_hold || dir_resp || (|bresp_val);
	assign done = procresp_val && procresp_rdy;

	a_resp_outstanding: assert property (@(posedge clk) disable iff (reset)
		memresp_val |-> outstanding);

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/cache_pkg.sv
hw/req_dispatch.sv
hw/cache_bank.sv
hw/resp_merge.sv
hw/cache_controller.sv
verif/mem_model.sv
verif/tb_cache_controller.sv

//--- verif/mem_model.sv
// Behavioral main memory with random accept and response delays
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module mem_model import cache_pkg::*; (
	input logic clk,
	input logic memreq_val,
	input logic memreq_we,
	input addr_u memreq_addr,
	input word_t memreq_wdata,
	output logic memreq_rdy,
	output logic memresp_val,
	output line_t memresp_line,
	output int req_count,
	output addr_u last_addr
);

	// Written words, keyed by word address
	word_t mem [int unsigned];
	logic busy;
	int delay;
	addr_u pend_addr;

	function automatic word_t fill_word(logic [31:0] a);
		return {a[15:0], ~a[31:16]};
	endfunction

	function automatic word_t read_word(logic [31:0] a);
		if (mem.exists(a[31:2])) begin
			return mem[a[31:2]];
		end
		return fill_word(a);
	endfunction

	initial begin
		memreq_rdy = 1'b0;
		memresp_val = 1'b0;
		memresp_line = '0;
		req_count = 0;
		last_addr = '0;
		busy = 1'b0;
		delay = 0;
		pend_addr = '0;
	end

	// Handshake decided here takes effect on the next rising edge
	always @(negedge clk) begin
		logic rdy_next;
		memresp_val = 1'b0;
		if (busy) begin
			memreq_rdy = 1'b0;
			if (delay == 0) begin
				for (int i = 0; i < `CC_LINE_WORDS; i++) begin
					memresp_line[i*`CC_WORD_W +: `CC_WORD_W] = read_word(pend_addr.flat + 4 * i);
				end
				memresp_val = 1'b1;
				busy = 1'b0;
			end else begin
				delay--;
			end
		end else begin
			rdy_next = ($urandom % 3) != 0;
			memreq_rdy = rdy_next;
			if (memreq_val && rdy_next) begin
				req_count++;
				last_addr = memreq_addr;
				pend_addr = memreq_addr;
				pend_addr.f.word = '0;
				pend_addr.f.byte_off = '0;
				if (memreq_we) begin
					mem[memreq_addr.flat[31:2]] = memreq_wdata;
				end
				delay = $urandom % 4;
				busy = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_cache_controller.sv
// Cache controller testbench with clock, reset, stimulus table, compare tasks and report
`default_nettype none
`timescale 1ns/10ps

`include "cache_config.svh"

module tb_cache_controller import cache_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic reset;
	logic procreq_val;
	logic procreq_we;
	logic procreq_domain;
	addr_u procreq_addr;
	word_t procreq_wdata;
	logic procreq_rdy;
	logic procresp_val;
	word_t procresp_data;
	logic procresp_rdy;
	logic memreq_val;
	logic memreq_we;
	addr_u memreq_addr;
	word_t memreq_wdata;
	logic memreq_rdy;
	logic memresp_val;
	line_t memresp_line;
	int mem_req_count;
	addr_u mem_last_addr;

	int checks;
	int error_count;
	int timeout_count;
	logic hung;

	// Stimulus table with one index per entry
	string t_name [$];
	logic t_we [$];
	addr_u t_addr [$];
	word_t t_data [$];
	logic t_domain [$];
	word_t t_exp_data [$];
	int t_exp_mem [$];

	// Shadow memory, boundary and line address held by each cache set
	word_t shadow_mem [int unsigned];
	logic [31:0] shadow_line [int unsigned];
	logic [31:0] shadow_boundary;

	cache_controller i_cache_controller (
		.clk(clk),
		.reset(reset),
		.procreq_val(procreq_val),
		.procreq_we(procreq_we),
		.procreq_domain(procreq_domain),
		.procreq_addr(procreq_addr),
		.procreq_wdata(procreq_wdata),
		.procreq_rdy(procreq_rdy),
		.procresp_val(procresp_val),
		.procresp_data(procresp_data),
		.procresp_rdy(procresp_rdy),
		.memreq_val(memreq_val),
		.memreq_we(memreq_we),
		.memreq_addr(memreq_addr),
		.memreq_wdata(memreq_wdata),
		.memreq_rdy(memreq_rdy),
		.memresp_val(memresp_val),
		.memresp_line(memresp_line)
	);

	mem_model i_mem (
		.clk(clk),
		.memreq_val(memreq_val),
		.memreq_we(memreq_we),
		.memreq_addr(memreq_addr),
		.memreq_wdata(memreq_wdata),
		.memreq_rdy(memreq_rdy),
		.memresp_val(memresp_val),
		.memresp_line(memresp_line),
		.req_count(mem_req_count),
		.last_addr(mem_last_addr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ---------------------------------------------------------------------
	// Compare tasks
	// ---------------------------------------------------------------------
	task automatic check_word(string name, word_t expected, word_t actual);
		checks++;
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_addr(string name, addr_u expected, addr_u actual);
		checks++;
		if (actual.flat !== expected.flat) begin
			$display("ERR %s: expected address %h, actual %h", name, expected.flat, actual.flat);
			error_count++;
		end
	endtask

	task automatic check_count(string name, int expected, int actual);
		checks++;
		if (actual != expected) begin
			$display("ERR %s: expected %0d memory requests, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	// ---------------------------------------------------------------------
	// Table and expected values
	// ---------------------------------------------------------------------
	function automatic word_t fill_word(logic [31:0] a);
		return {a[15:0], ~a[31:16]};
	endfunction

	function automatic word_t shadow_read(logic [31:0] a);
		if (shadow_mem.exists(a[31:2])) begin
			return shadow_mem[a[31:2]];
		end
		return fill_word(a);
	endfunction

	task automatic add_entry(string name, logic we, logic [31:0] addr, word_t data, logic domain);
		t_name.push_back(name);
		t_we.push_back(we);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_domain.push_back(domain);
	endtask

	task automatic predict_all();
		addr_u a;
		int unsigned set_idx;
		logic [31:0] line_addr;
		shadow_boundary = `CC_BOUNDARY_RESET;
		for (int i = 0; i < t_name.size(); i++) begin
			a = t_addr[i];
			set_idx = {a.f.index, a.f.bank};
			line_addr = a.flat & ~32'hf;
			t_exp_data.push_back('0);
			t_exp_mem.push_back(0);
			if (a.flat == `CC_CTRL_ADDR) begin
				if (t_domain[i] == `CC_DOMAIN_HIGH) begin
					shadow_boundary = t_data[i];
				end
			end else begin
				t_exp_mem[i] = 1;
				// Only cached reads fill a set
				if (a.flat != `CC_DIRECT_ADDR && a.flat < shadow_boundary && !t_we[i]) begin
					if (shadow_line.exists(set_idx) && shadow_line[set_idx] == line_addr) begin
						t_exp_mem[i] = 0;
					end
					shadow_line[set_idx] = line_addr;
				end
				if (t_we[i]) begin
					shadow_mem[a.flat[31:2]] = t_data[i];
				end else begin
					t_exp_data[i] = shadow_read(a.flat);
				end
			end
		end
	endtask

	// ---------------------------------------------------------------------
	// Apply one entry with random response back-pressure
	// ---------------------------------------------------------------------
	task automatic apply_entry(int i);
		int waited;
		int count_before;
		logic seen;
		logic got;
		logic rdy_next;
		word_t first_data;
		addr_u exp_addr;
		count_before = mem_req_count;
		@(negedge clk);
		procreq_val = 1'b1;
		procreq_we = t_we[i];
		procreq_addr = t_addr[i];
		procreq_wdata = t_data[i];
		procreq_domain = t_domain[i];
		waited = 0;
		while (!procreq_rdy && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!procreq_rdy) begin
			$display("Timeout: request %s was never accepted", t_name[i]);
			timeout_count++;
			hung = 1'b1;
			procreq_val = 1'b0;
			return;
		end
		@(negedge clk);
		procreq_val = 1'b0;
		got = 1'b0;
		seen = 1'b0;
		waited = 0;
		first_data = '0;
		while (!got && waited < TIMEOUT_CYCLES) begin
			rdy_next = ($urandom % 3) != 0;
			procresp_rdy = rdy_next;
			if (procresp_val) begin
				if (seen) begin
					check_word({t_name[i], " hold"}, first_data, procresp_data);
				end else begin
					first_data = procresp_data;
					seen = 1'b1;
				end
				got = rdy_next;
			end
			if (!got) begin
				@(negedge clk);
				waited++;
			end
		end
		if (!got) begin
			$display("Timeout: no response accepted for request %s", t_name[i]);
			timeout_count++;
			hung = 1'b1;
			return;
		end
		check_word(t_name[i], t_exp_data[i], first_data);
		check_count(t_name[i], t_exp_mem[i], mem_req_count - count_before);
		if (t_exp_mem[i] != 0) begin
			// Reads fetch whole lines
			exp_addr = t_addr[i];
			if (!t_we[i]) begin
				exp_addr.f.word = '0;
				exp_addr.f.byte_off = '0;
			end
			check_addr(t_name[i], exp_addr, mem_last_addr);
		end
	endtask

	initial begin
		void'($urandom(98));
		checks = 0;
		error_count = 0;
		timeout_count = 0;
		hung = 1'b0;
		reset = 1'b1;
		procreq_val = 1'b0;
		procreq_we = 1'b0;
		procreq_domain = 1'b0;
		procreq_addr = '0;
		procreq_wdata = '0;
		procresp_rdy = 1'b0;

		//        name                 we    addr        data          domain
		add_entry("rd_miss_a",         1'b0, 32'h0100, 32'h0,        1'b0);
		add_entry("rd_hit_a",          1'b0, 32'h0100, 32'h0,        1'b0);
		add_entry("rd_miss_b",         1'b0, 32'h0110, 32'h0,        1'b0);
		add_entry("rd_hit_b",          1'b0, 32'h0114, 32'h0,        1'b0);
		add_entry("rd_hit_a2",         1'b0, 32'h010c, 32'h0,        1'b0);
		add_entry("rd_uncached",       1'b0, 32'hc040, 32'h0,        1'b0);
		add_entry("rd_uncached2",      1'b0, 32'hc040, 32'h0,        1'b0);
		add_entry("rd_direct",         1'b0, 32'h0000, 32'h0,        1'b0);
		add_entry("rd_direct2",        1'b0, 32'h0000, 32'h0,        1'b1);
		add_entry("wr_hit",            1'b1, 32'h0104, 32'hdeadbeef, 1'b0);
		add_entry("rd_after_wr_hit",   1'b0, 32'h0104, 32'h0,        1'b0);
		add_entry("wr_miss",           1'b1, 32'h0228, 32'h12345678, 1'b0);
		add_entry("rd_after_wr_miss",  1'b0, 32'h0228, 32'h0,        1'b0);
		add_entry("wr_direct",         1'b1, 32'h0000, 32'hcafe0001, 1'b0);
		add_entry("rd_direct3",        1'b0, 32'h0000, 32'h0,        1'b0);
		add_entry("ctrl_low",          1'b1, 32'h0004, 32'h0100,     1'b0);
		add_entry("rd_still_cached",   1'b0, 32'h0100, 32'h0,        1'b0);
		add_entry("ctrl_high",         1'b1, 32'h0004, 32'h0100,     1'b1);
		add_entry("rd_now_uncached",   1'b0, 32'h0100, 32'h0,        1'b0);
		add_entry("rd_below",          1'b0, 32'h0080, 32'h0,        1'b0);
		add_entry("ctrl_restore",      1'b1, 32'h0004, 32'hc000,     1'b1);
		add_entry("rd_cached_again",   1'b0, 32'h0100, 32'h0,        1'b0);
		add_entry("rd_evict",          1'b0, 32'h1108, 32'h0,        1'b0);
		add_entry("rd_refetch",        1'b0, 32'h0104, 32'h0,        1'b0);
		add_entry("rd_ctrl_low",       1'b0, 32'h0004, 32'h0,        1'b0);
		predict_all();

		repeat (16) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < t_name.size() && !hung; i++) begin
			apply_entry(i);
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0 && !hung) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
